// File: logic/audio_shifter.sv
////////////////////////////////////////
// I2S audio shifter
// Left and right DAC samples, optional swap
////////////////////////////////////////

`timescale 1ns/1ps

module audio_shifter
  import minimig_mem_pkg::*;
#(
  parameter int BCLK_DIV = 2             // Bit clock half-period in clk_114 cycles
) (
  input  logic    clk_114,
  input  logic    sys_rst_n,
  input  sample_t left,                  // Left sample
  input  sample_t right,                 // Right sample
  input  logic    exchan,                // Swap channels
  output logic    aud_bclk,
  output logic    aud_daclrck,
  output logic    aud_dacdat
);

  localparam int DW         = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
  localparam int FRAME_BITS = 2 * $bits(sample_t);   // Bit clocks per frame
  localparam int PW         = $clog2(FRAME_BITS);

  logic [DW-1:0]         div_q;          // Half-period divider
  logic                  tick;           // Bit clock toggles
  logic                  fall;           // Bit clock falls
  logic [PW-1:0]         pos_q;          // Bit slot within frame
  logic [PW-1:0]         pos_nx;
  logic [FRAME_BITS-1:0] sr_q;           // Frame shift register

  ////////////////////////////////////////
  // Bit clock

  assign tick = (div_q == DW'(BCLK_DIV - 1));
  assign fall = tick && aud_bclk;        // High to low transition

  always_ff @(posedge clk_114 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      div_q    <= '0;
      aud_bclk <= 1'b0;
    end else if (tick) begin
      div_q    <= '0;
      aud_bclk <= !aud_bclk;
    end else begin
      div_q    <= div_q + DW'(1);
    end
  end

  ////////////////////////////////////////
  // Frame position and LR clock

  assign pos_nx = pos_q + PW'(1);

  always_ff @(posedge clk_114 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      pos_q       <= '1;                 // First fall opens slot 0
      aud_daclrck <= 1'b0;
    end else if (fall) begin
      pos_q       <= pos_nx;
      aud_daclrck <= pos_nx[PW-1];       // Low half left, high half right
    end
  end

  ////////////////////////////////////////
  // Data shifter

  // Output lags the LR clock by one bit, so the last right LSB
  // leaves in slot 0 of the next frame
  always_ff @(posedge clk_114 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sr_q       <= '0;
      aud_dacdat <= 1'b0;
    end else if (fall) begin
      aud_dacdat <= sr_q[FRAME_BITS-1];  // MSB first
      if (pos_nx == '0) begin
        sr_q <= exchan ? {right, left} : {left, right};  // Frame start capture
      end else begin
        sr_q <= {sr_q[FRAME_BITS-2:0], 1'b0};
      end
    end
  end

endmodule

// File: logic/mem_port.sv
////////////////////////////////////////
// Requester port
// Holds one request until its slot comes up
////////////////////////////////////////

`timescale 1ns/1ps

module mem_port
  import minimig_mem_pkg::*;
#(
  parameter type addr_t = chip_addr_t   // Chipset or control address
) (
  input  logic  clk_114,
  input  logic  sys_rst_n,
  // Requester side
  input  logic  req,          // One-cycle strobe
  input  logic  we,           // Write when high
  input  addr_t addr,         // Word address
  input  word_t wdata,        // Write data
  input  be_t   be,           // Byte enables
  // Arbiter side
  input  logic  grant,        // Memory access this cycle
  input  logic  done,         // Read data valid this cycle
  input  word_t rd_word,      // Memory read or merged word
  output logic  pending,      // Request waiting for its slot
  output logic  p_we,
  output addr_t p_addr,
  output word_t p_wdata,
  output be_t   p_be,
  // Back to requester
  output logic  ack,          // One-cycle completion pulse
  output word_t rdata         // Valid with ack, held until next ack
);

  word_t rdata_q;             // Last returned word

  logic  take;                // Strobe accepted

  assign take = req && !pending;  // Busy port drops the strobe

  // Pending flag, set on strobe and cleared by the grant
  always_ff @(posedge clk_114 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      pending <= 1'b0;
    end else if (take) begin
      pending <= 1'b1;
    end else if (grant) begin
      pending <= 1'b0;          // Memory has taken it
    end
  end

  // Request fields, frozen while pending
  always_ff @(posedge clk_114) begin
    if (take) begin
      p_we    <= we;
      p_addr  <= addr;
      p_wdata <= wdata;
      p_be    <= be;
    end
  end

  // Keep the word for the cycles after ack
  always_ff @(posedge clk_114) begin
    if (done) begin
      rdata_q <= rd_word;
    end
  end

  assign ack   = done;                          // Done is routed to this port only
  assign rdata = done ? rd_word : rdata_q;      // Fresh word in the ack cycle

endmodule

// File: logic/minimig_mem_pkg.sv
////////////////////////////////////////
// Shared memory core definitions
// Word, address, sample and slot types
////////////////////////////////////////

package minimig_mem_pkg;

  ////////////////////////////////////////
  // Widths

  localparam int WORD_W   = 16;   // Memory data word
  localparam int BE_W     = 2;    // One enable per byte lane
  localparam int CHIP_AW  = 21;   // Chip RAM word address bus
  localparam int CTL_AW   = 23;   // Control CPU word address (24-bit byte)
  localparam int DAC_W    = 15;   // Paula DAC sample width
  localparam int SAMPLE_W = 16;   // Padded I2S sample
  localparam int SLOT_W   = 2;    // Four slots per round

  ////////////////////////////////////////
  // Types

  typedef logic [WORD_W-1:0]   word_t;       // Memory data word
  typedef logic [BE_W-1:0]     be_t;         // Bit 0 low byte, bit 1 high byte
  typedef logic [CHIP_AW-1:0]  chip_addr_t;  // Chipset word address
  typedef logic [CTL_AW-1:0]   ctl_addr_t;   // Control port word address
  typedef logic [SAMPLE_W-1:0] sample_t;     // Audio sample, MSB first on the wire
  typedef logic [SLOT_W-1:0]   slot_t;       // Arbiter slot number

  ////////////////////////////////////////
  // Slot ownership

  // Slots 1 and 3 stay idle so each peer has a fixed turn
  localparam slot_t SLOT_CHIP = slot_t'(0);  // Chipset turn
  localparam slot_t SLOT_CTL  = slot_t'(2);  // Control CPU turn

endpackage

// File: logic/minimig_mem_top.sv
////////////////////////////////////////
// Minimig shared memory core
// Arbitrated memory, I2S audio and reset
////////////////////////////////////////

`timescale 1ns/1ps

module minimig_mem_top
  import minimig_mem_pkg::*;
#(
  parameter int MEM_AW     = 10,         // Shared memory word address width
  parameter int RESET_HOLD = 16,         // Reset hold after release
  parameter int BCLK_DIV   = 2           // Audio bit clock half-period
) (
  input  logic             clk_114,
  input  logic             arst_n,
  output logic             mem_ready,
  // Chipset port
  input  logic             chip_req,
  input  logic             chip_we,
  input  chip_addr_t       chip_addr,
  input  word_t            chip_wdata,
  input  be_t              chip_be,
  output logic             chip_ack,
  output word_t            chip_rdata,
  // Control CPU port
  input  logic             ctl_req,
  input  logic             ctl_we,
  input  ctl_addr_t        ctl_addr,
  input  word_t            ctl_wdata,
  input  be_t              ctl_be,
  output logic             ctl_ack,
  output word_t            ctl_rdata,
  // Audio
  input  logic [DAC_W-1:0] ldata,        // Left DAC data
  input  logic [DAC_W-1:0] rdata,        // Right DAC data
  input  logic             exchan,       // Channel swap switch
  output logic             aud_bclk,
  output logic             aud_daclrck,
  output logic             aud_dacdat
);

  ////////////////////////////////////////
  // Internal signals

  logic              sys_rst_n;
  // Chipset held request
  logic              chip_pending, chip_p_we;
  chip_addr_t        chip_p_addr;
  word_t             chip_p_wdata;
  be_t               chip_p_be;
  logic              chip_grant, chip_done;
  // Control held request
  logic              ctl_pending, ctl_p_we;
  ctl_addr_t         ctl_p_addr;
  word_t             ctl_p_wdata;
  be_t               ctl_p_be;
  logic              ctl_grant, ctl_done;
  // Memory bus
  logic              mem_en, mem_we;
  logic [MEM_AW-1:0] mem_addr;
  word_t             mem_wdata;
  be_t               mem_be;
  word_t             rd_word;

  ////////////////////////////////////////
  // Blocks

  reset_seq #(.RESET_HOLD(RESET_HOLD)) u_reset_seq (
    .clk_114   (clk_114   ),
    .arst_n    (arst_n    ),
    .sys_rst_n (sys_rst_n ),
    .mem_ready (mem_ready )
  );

  mem_port #(.addr_t(chip_addr_t)) u_chip_port (
    .clk_114 (clk_114     ), .sys_rst_n (sys_rst_n   ),
    .req     (chip_req    ), .we        (chip_we     ),
    .addr    (chip_addr   ), .wdata     (chip_wdata  ),
    .be      (chip_be     ), .grant     (chip_grant  ),
    .done    (chip_done   ), .rd_word   (rd_word     ),
    .pending (chip_pending), .p_we      (chip_p_we   ),
    .p_addr  (chip_p_addr ), .p_wdata   (chip_p_wdata),
    .p_be    (chip_p_be   ), .ack       (chip_ack    ),
    .rdata   (chip_rdata  )
  );

  mem_port #(.addr_t(ctl_addr_t)) u_ctl_port (
    .clk_114 (clk_114    ), .sys_rst_n (sys_rst_n  ),
    .req     (ctl_req    ), .we        (ctl_we     ),
    .addr    (ctl_addr   ), .wdata     (ctl_wdata  ),
    .be      (ctl_be     ), .grant     (ctl_grant  ),
    .done    (ctl_done   ), .rd_word   (rd_word    ),
    .pending (ctl_pending), .p_we      (ctl_p_we   ),
    .p_addr  (ctl_p_addr ), .p_wdata   (ctl_p_wdata),
    .p_be    (ctl_p_be   ), .ack       (ctl_ack    ),
    .rdata   (ctl_rdata  )
  );

  slot_arbiter #(.MEM_AW(MEM_AW)) u_slot_arbiter (
    .clk_114      (clk_114     ), .sys_rst_n  (sys_rst_n   ),
    .chip_pending (chip_pending), .chip_we    (chip_p_we   ),
    .chip_addr    (chip_p_addr ), .chip_wdata (chip_p_wdata),
    .chip_be      (chip_p_be   ), .ctl_pending(ctl_pending ),
    .ctl_we       (ctl_p_we    ), .ctl_addr   (ctl_p_addr  ),
    .ctl_wdata    (ctl_p_wdata ), .ctl_be     (ctl_p_be    ),
    .chip_grant   (chip_grant  ), .chip_done  (chip_done   ),
    .ctl_grant    (ctl_grant   ), .ctl_done   (ctl_done    ),
    .mem_en       (mem_en      ), .mem_we     (mem_we      ),
    .mem_addr     (mem_addr    ), .mem_wdata  (mem_wdata   ),
    .mem_be       (mem_be      )
  );

  shared_ram #(.MEM_AW(MEM_AW)) u_shared_ram (
    .clk_114   (clk_114  ),
    .mem_en    (mem_en   ),
    .mem_we    (mem_we   ),
    .mem_addr  (mem_addr ),
    .mem_wdata (mem_wdata),
    .mem_be    (mem_be   ),
    .rd_word   (rd_word  )
  );

  audio_shifter #(.BCLK_DIV(BCLK_DIV)) u_audio_shifter (
    .clk_114     (clk_114       ),
    .sys_rst_n   (sys_rst_n     ),
    .left        ({ldata, 1'b0} ),  // Pad DAC value to 16 bits
    .right       ({rdata, 1'b0} ),
    .exchan      (exchan        ),
    .aud_bclk    (aud_bclk      ),
    .aud_daclrck (aud_daclrck   ),
    .aud_dacdat  (aud_dacdat    )
  );

endmodule

// File: logic/reset_seq.sv
////////////////////////////////////////
// Reset sequencer
// Synchronised release plus hold count
////////////////////////////////////////

`timescale 1ns/1ps

module reset_seq #(
  parameter int RESET_HOLD = 16          // Cycles held after release
) (
  input  logic clk_114,
  input  logic arst_n,                   // Board reset
  output logic sys_rst_n,                // Released after the hold count
  output logic mem_ready                 // Ports may take strobes
);

  localparam int CW = $clog2(RESET_HOLD + 1);

  logic [1:0]    sync_q;                 // Release synchroniser
  logic [CW-1:0] cnt_q;                  // Hold counter

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      sync_q    <= '0;
      cnt_q     <= '0;
      sys_rst_n <= 1'b0;
      mem_ready <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
      if (sync_q[1] && !sys_rst_n) begin
        cnt_q <= cnt_q + CW'(1);
        if (cnt_q == CW'(RESET_HOLD - 1)) begin
          sys_rst_n <= 1'b1;             // End of hold
        end
      end
      mem_ready <= sys_rst_n;            // One cycle after the ports leave reset
    end
  end

endmodule

// File: logic/shared_ram.sv
////////////////////////////////////////
// Shared word memory
// On-chip stand-in for the board SDRAM
////////////////////////////////////////

`timescale 1ns/1ps

module shared_ram
  import minimig_mem_pkg::*;
#(
  parameter int MEM_AW = 10              // Word address width
) (
  input  logic              clk_114,
  input  logic              mem_en,      // One access this cycle
  input  logic              mem_we,      // Write when high
  input  logic [MEM_AW-1:0] mem_addr,
  input  word_t             mem_wdata,
  input  be_t               mem_be,      // Active-high byte enables
  output word_t             rd_word      // Registered read or merged word
);

  word_t mem [2**MEM_AW];

  word_t old_word;                       // Current contents at mem_addr
  word_t merged;                         // Old word with enabled lanes replaced

  assign old_word = mem[mem_addr];

  always_comb begin
    merged[7:0]  = mem_be[0] ? mem_wdata[7:0]  : old_word[7:0];   // Low lane
    merged[15:8] = mem_be[1] ? mem_wdata[15:8] : old_word[15:8];  // High lane
  end

  always_ff @(posedge clk_114) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[mem_addr] <= merged;
        rd_word       <= merged;         // Write returns what was stored
      end else begin
        rd_word       <= old_word;
      end
    end
  end

endmodule

// File: logic/slot_arbiter.sv
////////////////////////////////////////
// Fixed slot arbiter
// Chipset and control CPU share one memory
////////////////////////////////////////

`timescale 1ns/1ps

module slot_arbiter
  import minimig_mem_pkg::*;
#(
  parameter int MEM_AW = 10            // Memory word address width
) (
  input  logic              clk_114,
  input  logic              sys_rst_n,
  // Chipset held request
  input  logic              chip_pending,
  input  logic              chip_we,
  input  chip_addr_t        chip_addr,
  input  word_t             chip_wdata,
  input  be_t               chip_be,
  // Control CPU held request
  input  logic              ctl_pending,
  input  logic              ctl_we,
  input  ctl_addr_t         ctl_addr,
  input  word_t             ctl_wdata,
  input  be_t               ctl_be,
  // Grants and completions
  output logic              chip_grant,
  output logic              chip_done,
  output logic              ctl_grant,
  output logic              ctl_done,
  // Memory side
  output logic              mem_en,
  output logic              mem_we,
  output logic [MEM_AW-1:0] mem_addr,
  output word_t             mem_wdata,
  output be_t               mem_be
);

  slot_t             slot_q;           // Free-running slot counter
  logic [MEM_AW-1:0] chip_maddr;       // Chipset address after region forcing
  logic [MEM_AW-1:0] ctl_maddr;        // Control address, full range

  ////////////////////////////////////////
  // Slot counter

  always_ff @(posedge clk_114 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_q + slot_t'(1);   // Wraps every four cycles
    end
  end

  // Each peer only ever gets its own slot
  assign chip_grant = chip_pending && (slot_q == SLOT_CHIP);
  assign ctl_grant  = ctl_pending  && (slot_q == SLOT_CTL);

  ////////////////////////////////////////
  // Address map and memory mux

  // Chip RAM sits in the upper half, like the board's region prefix
  assign chip_maddr = {1'b1, chip_addr[MEM_AW-2:0]};
  assign ctl_maddr  = ctl_addr[MEM_AW-1:0];

  assign mem_en = chip_grant || ctl_grant;

  always_comb begin
    if (chip_grant) begin
      mem_we    = chip_we;
      mem_addr  = chip_maddr;
      mem_wdata = chip_wdata;
      mem_be    = chip_be;
    end else begin                      // Control fields also while idle
      mem_we    = ctl_we;
      mem_addr  = ctl_maddr;
      mem_wdata = ctl_wdata;
      mem_be    = ctl_be;
    end
  end

  ////////////////////////////////////////
  // Completion, one cycle behind the grant

  always_ff @(posedge clk_114 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      chip_done <= 1'b0;
      ctl_done  <= 1'b0;
    end else begin
      chip_done <= chip_grant;          // Lines up with registered read data
      ctl_done  <= ctl_grant;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the shared memory core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
  --top-module tb_minimig_mem -o tb_minimig_mem > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_minimig_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "No result line found in sim.log"
  exit 1
fi
exit 0

// File: sim/tb_minimig_mem.sv
////////////////////////////////////////
// Testbench for the shared memory core
// Table-driven port traffic plus I2S check
////////////////////////////////////////

`timescale 1ns/1ps

module tb_minimig_mem
  import minimig_mem_pkg::*;
;

  localparam int  MEM_AW     = 10;
  localparam int  RESET_HOLD = 16;
  localparam int  BCLK_DIV   = 2;
  localparam int  N_TXN      = 16;                    // Table entries
  localparam int  FRAME_CYC  = 2 * BCLK_DIV * 32;     // clk_114 cycles per I2S frame
  localparam int  LIMIT_CYC  = 10 + RESET_HOLD + 3 + N_TXN * 10 + 3 * FRAME_CYC;
  localparam bit  PORT_CHIP  = 1'b0;
  localparam bit  PORT_CTL   = 1'b1;

  logic             clk_114, arst_n, mem_ready;
  logic             chip_req, chip_we, chip_ack;
  chip_addr_t       chip_addr;
  word_t            chip_wdata, chip_rdata;
  be_t              chip_be;
  logic             ctl_req, ctl_we, ctl_ack;
  ctl_addr_t        ctl_addr;
  word_t            ctl_wdata, ctl_rdata;
  be_t              ctl_be;
  logic [DAC_W-1:0] ldata, rdata;                     // DAC samples
  logic             exchan, aud_bclk, aud_daclrck, aud_dacdat;
  logic             audio_done;                       // Audio checker finished

  // Stimulus table
  bit               t_port  [N_TXN];
  bit               t_we    [N_TXN];
  ctl_addr_t        t_addr  [N_TXN];                  // Chipset entries use the low 21 bits
  be_t              t_be    [N_TXN];
  word_t            t_wdata [N_TXN];
  word_t            t_exp   [N_TXN];

  word_t            ref_mem [2**MEM_AW];              // Expected memory contents
  logic [31:0]      rng;
  int               word_errs, sample_errs, proto_errs, word_checks, sample_checks;

  minimig_mem_top #(.MEM_AW(MEM_AW), .RESET_HOLD(RESET_HOLD), .BCLK_DIV(BCLK_DIV)) u_dut (
    .clk_114    (clk_114   ), .arst_n      (arst_n     ), .mem_ready  (mem_ready ),
    .chip_req   (chip_req  ), .chip_we     (chip_we    ), .chip_addr  (chip_addr ),
    .chip_wdata (chip_wdata), .chip_be     (chip_be    ), .chip_ack   (chip_ack  ),
    .chip_rdata (chip_rdata), .ctl_req     (ctl_req    ), .ctl_we     (ctl_we    ),
    .ctl_addr   (ctl_addr  ), .ctl_wdata   (ctl_wdata  ), .ctl_be     (ctl_be    ),
    .ctl_ack    (ctl_ack   ), .ctl_rdata   (ctl_rdata  ), .ldata      (ldata     ),
    .rdata      (rdata     ), .exchan      (exchan     ), .aud_bclk   (aud_bclk  ),
    .aud_daclrck(aud_daclrck), .aud_dacdat (aud_dacdat )
  );

  initial begin
    clk_114 = 1'b0;
    forever #4 clk_114 = ~clk_114;                    // 8 ns period
  end

  ////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Memory word address seen by each port
  function automatic logic [MEM_AW-1:0] map_addr(input bit port, input ctl_addr_t addr);
    logic [MEM_AW-1:0] m;
    m = addr[MEM_AW-1:0];
    if (port == PORT_CHIP) m[MEM_AW-1] = 1'b1;        // Chip RAM region bit
    return m;
  endfunction

  // Applies one access to the reference memory, returns the expected rdata
  function automatic word_t ref_access(input bit port, input bit we, input ctl_addr_t addr,
                                       input be_t be, input word_t wd);
    logic [MEM_AW-1:0] m;
    word_t             w;
    m = map_addr(port, addr);
    w = ref_mem[m];
    if (we) begin
      if (be[0]) w[7:0]  = wd[7:0];                   // Low lane
      if (be[1]) w[15:8] = wd[15:8];                  // High lane
      ref_mem[m] = w;
    end
    return w;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    word_checks++;
    if (got !== exp) begin
      word_errs++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    sample_checks++;
    if (got !== exp) begin
      sample_errs++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_idle();
    if (mem_ready || chip_ack || ctl_ack || aud_bclk || aud_daclrck || aud_dacdat) begin
      proto_errs++;
      $display("%0t mem_ready, an ack or an audio output is high before the end of reset",
               $time);
    end
  endtask

  task automatic add_entry(inout int n, input bit port, input bit we, input ctl_addr_t addr,
                           input be_t be, input word_t wd);
    t_port[n]  = port;
    t_we[n]    = we;
    t_addr[n]  = addr;
    t_be[n]    = be;
    t_wdata[n] = wd;
    t_exp[n]   = ref_access(port, we, addr, be, wd);
    n++;
  endtask

  task automatic build_table();
    be_t        be_seq [4];
    ctl_addr_t  a0;
    ctl_addr_t  ta;
    chip_addr_t ca;
    int         n;
    be_seq = '{2'b11, 2'b01, 2'b10, 2'b00};           // Full write first
    n      = 0;
    a0     = ctl_addr_t'(next_rand());
    for (int i = 0; i < 4; i++) begin                 // Byte lanes from the control port
      add_entry(n, PORT_CTL, 1'b1, a0, be_seq[i], word_t'(next_rand()));
      add_entry(n, PORT_CTL, 1'b0, a0, 2'b11, '0);
    end
    for (int i = 0; i < 2; i++) begin                 // Chipset word seen by control port
      ca             = chip_addr_t'(next_rand());
      ca[MEM_AW-1]   = 1'b0;                          // Forced to 1 inside the DUT
      ta             = ctl_addr_t'(next_rand());
      ta[MEM_AW-1:0] = {1'b1, ca[MEM_AW-2:0]};
      add_entry(n, PORT_CHIP, 1'b1, ctl_addr_t'(ca), 2'b11, word_t'(next_rand()));
      add_entry(n, PORT_CTL, 1'b0, ta, 2'b11, '0);
      add_entry(n, PORT_CHIP, 1'b0, ctl_addr_t'(ca), 2'b11, '0);
    end
    // Control write in the upper half, read back through the chipset
    ta             = ctl_addr_t'(next_rand());
    ta[MEM_AW-1]   = 1'b1;
    ca             = chip_addr_t'(next_rand());
    ca[MEM_AW-1:0] = {1'b0, ta[MEM_AW-2:0]};
    add_entry(n, PORT_CTL, 1'b1, ta, 2'b11, word_t'(next_rand()));
    add_entry(n, PORT_CHIP, 1'b0, ctl_addr_t'(ca), 2'b11, '0);
  endtask

  ////////////////////////////////////////
  // Port traffic

  task automatic run_txn(input bit port, input bit we, input ctl_addr_t addr, input be_t be,
                         input word_t wd, input word_t exp);
    string name;
    int    cyc;
    logic  got_ack;
    word_t got;
    name = (port == PORT_CHIP) ? "chip_rdata" : "ctl_rdata";
    if (port == PORT_CHIP) begin
      chip_req   = 1'b1;
      chip_we    = we;
      chip_addr  = chip_addr_t'(addr);
      chip_wdata = wd;
      chip_be    = be;
    end else begin
      ctl_req   = 1'b1;
      ctl_we    = we;
      ctl_addr  = addr;
      ctl_wdata = wd;
      ctl_be    = be;
    end
    cyc     = 0;
    got_ack = 1'b0;
    got     = '0;
    while (!got_ack && cyc < 5) begin                 // Ack due within 5 cycles
      @(posedge clk_114);
      #1;
      chip_req = 1'b0;
      ctl_req  = 1'b0;
      cyc++;
      got_ack  = (port == PORT_CHIP) ? chip_ack : ctl_ack;
      got      = (port == PORT_CHIP) ? chip_rdata : ctl_rdata;
    end
    if (!got_ack) begin
      proto_errs++;
      $display("%0t No ack on the %s port within 5 cycles", $time, port ? "control" : "chipset");
    end else begin
      check_word(name, got, exp);
      @(posedge clk_114);
      #1;
      if ((port == PORT_CHIP) ? chip_ack : ctl_ack) begin
        proto_errs++;
        $display("%0t Ack lasted longer than one cycle", $time);
      end
      check_word(name, (port == PORT_CHIP) ? chip_rdata : ctl_rdata, exp);  // Held after ack
    end
  endtask

  // Both ports strobe together, then strobe again while pending
  task automatic run_pair(input bit we, input chip_addr_t ca, input ctl_addr_t ta,
                          input word_t cwd, input word_t twd);
    word_t ce;
    word_t te;
    int    c_acks;
    int    t_acks;
    ce     = ref_access(PORT_CHIP, we, ctl_addr_t'(ca), 2'b11, cwd);
    te     = ref_access(PORT_CTL, we, ta, 2'b11, twd);
    c_acks = 0;
    t_acks = 0;
    chip_req   = 1'b1;
    chip_we    = we;
    chip_addr  = ca;
    chip_wdata = cwd;
    chip_be    = 2'b11;
    ctl_req    = 1'b1;
    ctl_we     = we;
    ctl_addr   = ta;
    ctl_wdata  = twd;
    ctl_be     = 2'b11;
    for (int cyc = 1; cyc <= 8; cyc++) begin
      @(posedge clk_114);
      #1;
      chip_req   = (cyc == 1);                        // Second strobe must be dropped
      ctl_req    = (cyc == 1);
      chip_wdata = ~cwd;
      ctl_wdata  = ~twd;
      if (chip_ack) begin
        c_acks++;
        check_word("chip_rdata", chip_rdata, ce);
      end
      if (ctl_ack) begin
        t_acks++;
        check_word("ctl_rdata", ctl_rdata, te);
      end
      if (cyc == 5 && (c_acks == 0 || t_acks == 0)) begin
        proto_errs++;
        $display("%0t Simultaneous request not acked within 5 cycles", $time);
      end
    end
    if (c_acks != 1 || t_acks != 1) begin
      proto_errs++;
      $display("%0t Expected one ack per port, saw %0d chipset and %0d control",
               $time, c_acks, t_acks);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin : main_seq
    logic [31:0] r;
    ctl_addr_t   pair_ta;
    int          cyc;
    chip_req    = 1'b0;
    chip_we     = 1'b0;
    chip_addr   = '0;
    chip_wdata  = '0;
    chip_be     = '0;
    ctl_req     = 1'b0;
    ctl_we      = 1'b0;
    ctl_addr    = '0;
    ctl_wdata   = '0;
    ctl_be      = '0;
    word_errs   = 0;
    proto_errs  = 0;
    word_checks = 0;
    arst_n = 1'b0;
    rng    = 32'hbbbb;
    r      = next_rand();
    ldata  = r[DAC_W-1:0];
    r      = next_rand();
    rdata  = r[DAC_W-1:0];
    build_table();
    repeat (10) begin                                 // Reset held for 10 cycles
      @(posedge clk_114);
      #1;
      check_idle();
    end
    arst_n = 1'b1;
    cyc    = 0;
    while (!mem_ready && cyc < RESET_HOLD + 3) begin
      check_idle();
      @(posedge clk_114);
      #1;
      cyc++;
    end
    if (!mem_ready) begin
      proto_errs++;
      $display("%0t mem_ready did not rise within %0d cycles of reset release",
               $time, RESET_HOLD + 3);
    end
    for (int i = 0; i < N_TXN; i++) begin
      run_txn(t_port[i], t_we[i], t_addr[i], t_be[i], t_wdata[i], t_exp[i]);
    end
    r                 = next_rand();
    pair_ta           = ctl_addr_t'(r[31:MEM_AW]);
    pair_ta[MEM_AW-1] = 1'b0;                         // Control in lower half
    run_pair(1'b1, chip_addr_t'(r), pair_ta, word_t'(next_rand()), word_t'(next_rand()));
    run_pair(1'b0, chip_addr_t'(r), pair_ta, '0, '0);
    wait (audio_done);
    $display("Word checks %0d, word errors %0d, sample checks %0d, sample errors %0d, %s %0d",
             word_checks, word_errs, sample_checks, sample_errs, "protocol errors", proto_errs);
    if (word_errs + sample_errs + proto_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Audio checker and watchdog

  initial begin : audio_check
    logic [31:0] sh;                                  // Last 32 bits off the wire
    logic        prev_lr;
    int          frames;
    sample_t     exp_l;
    sample_t     exp_r;
    exchan        = 1'b0;
    audio_done    = 1'b0;
    sample_errs   = 0;
    sample_checks = 0;
    sh            = '0;
    prev_lr       = 1'b0;
    frames        = 0;
    while (frames < 3) begin
      @(posedge aud_bclk);
      sh = {sh[30:0], aud_dacdat};                    // One bit per rising edge
      if (prev_lr && !aud_daclrck) begin              // Slot 0 closes the previous frame
        frames++;
        exp_l = {ldata, 1'b0};
        exp_r = {rdata, 1'b0};
        if (frames == 3) begin                        // Captured with exchan high
          check_sample("aud_dacdat left", sh[31:16], exp_r);
          check_sample("aud_dacdat right", sh[15:0], exp_l);
        end else begin
          check_sample("aud_dacdat left", sh[31:16], exp_l);
          check_sample("aud_dacdat right", sh[15:0], exp_r);
        end
        if (frames == 1) begin
          @(posedge clk_114);
          #1;
          exchan = 1'b1;                              // Takes effect at the next frame start
        end
      end
      prev_lr = aud_daclrck;
    end
    audio_done = 1'b1;
  end

  initial begin : watchdog
    repeat (LIMIT_CYC) @(posedge clk_114);
    $display("Timeout after %0d cycles, the run did not complete", LIMIT_CYC);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: vlog.f
logic/minimig_mem_pkg.sv
logic/mem_port.sv
logic/slot_arbiter.sv
logic/shared_ram.sv
logic/audio_shifter.sv
logic/reset_seq.sv
logic/minimig_mem_top.sv
sim/tb_minimig_mem.sv
